/* huff_pkg.sv */
package huff_pkg;

  // widths that carry a meaning in the header format and on the host bus
  typedef logic [7:0]  byte_t;      // one header byte as delivered by the byte source
  typedef logic [7:0]  sym_t;       // symbol value which is also the codebook index
  typedef logic [7:0]  len_t;       // code length in tree levels
  typedef logic [31:0] tot_t;       // total symbol count that follows the tree
  typedef logic [7:0]  apb_addr_t;  // byte address inside the register block
  typedef logic [31:0] apb_data_t;  // APB read and write data word

  // tree walking FSM of hd_decode
  typedef enum logic [2:0] {
    IDLE      = 3'd0,  // waiting for the host to start a decode
    TREE_BIT  = 3'd1,  // reading one pre-order tree bit
    LEAF_SYM  = 3'd2,  // shifting in the 8 symbol bits of a leaf
    WRITE     = 3'd3,  // storing the finished code in the codebook
    BACKTRACK = 3'd4,  // popping right moves until a left move can turn right
    TOTAL     = 3'd5,  // shifting in the 32 bit symbol total
    DONE      = 3'd6,  // header fully parsed and results are stable
    ERROR     = 3'd7   // a path went deeper than the codebook can hold
  } dec_state_e;

  // register map seen by the host
  localparam apb_addr_t REG_CTRL   = 8'h00;  // bit 0 starts a decode when written with 1
  localparam apb_addr_t REG_STATUS = 8'h04;  // busy in bit 0 with done and error above it
  localparam apb_addr_t REG_TOTAL  = 8'h08;  // symbol total captured from the header
  localparam apb_addr_t REG_INDEX  = 8'h0C;  // codebook entry selected for REG_CODE
  localparam apb_addr_t REG_CODE   = 8'h10;  // valid and length and code of that entry

  // field positions inside the REG_STATUS word
  localparam int STAT_BUSY  = 0;  // decode in progress
  localparam int STAT_DONE  = 1;  // last decode finished cleanly
  localparam int STAT_ERROR = 2;  // last decode stopped on a path that was too deep

  // field positions inside the REG_CODE word
  localparam int CODE_VALID_BIT = 31;  // entry was written by the last decode
  localparam int CODE_LEN_LSB   = 24;  // length occupies bits 30 down to 24
  localparam int CODE_FIELD_W   = 24;  // code is right aligned in the low 24 bits

endpackage

/* hd_bit_fetch.sv */
`timescale 1ns/1ps

module hd_bit_fetch import huff_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  flush,       // drop whatever is left of the current byte
  input  logic  need,        // decoder sits in a state that consumes bits
  output logic  byte_req,    // one cycle request to the byte source
  input  logic  byte_valid,  // source answer after one or more cycles
  input  byte_t byte_data,
  output logic  bit_valid,   // a bit is on offer
  output logic  bit_data,
  input  logic  bit_take     // decoder consumes the offered bit
);

  byte_t      buf_q;   // current header byte
  logic [2:0] pos_q;   // index of the next bit to serve and 7 comes first
  logic       full_q;  // buf_q still holds unread bits
  logic       pend_q;  // a request is out and its byte has not come back
  logic       req_q;   // registered request pulse
  logic       ask;     // conditions for a new request are met this cycle

  // only ask when empty with nothing in flight and the pulse not already out
  assign ask = need && !full_q && !pend_q && !req_q && !flush;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      buf_q  <= '0;
      pos_q  <= '0;
      full_q <= 1'b0;
      pend_q <= 1'b0;
      req_q  <= 1'b0;
    end else begin
      req_q <= ask;  // stays high for a single cycle since ask sees req_q
      if (ask) begin
        pend_q <= 1'b1;  // one request outstanding at a time
      end
      if (byte_valid) begin
        pend_q <= 1'b0;
      end
      if (flush) begin
        full_q <= 1'b0;  // leftover bits of the old stream are discarded
        pos_q  <= '0;
      end else if (byte_valid) begin
        buf_q  <= byte_data;
        pos_q  <= 3'd7;  // serve MSB first
        full_q <= 1'b1;
      end else if (bit_take && full_q) begin
        if (pos_q == 3'd0) begin
          full_q <= 1'b0;  // last bit gone so the next cycle can ask again
        end else begin
          pos_q <= pos_q - 3'd1;
        end
      end
    end
  end

  assign byte_req  = req_q;
  assign bit_valid = full_q;
  assign bit_data  = buf_q[pos_q];  // selected bit of the held byte

endmodule

/* hd_decode.sv */
`timescale 1ns/1ps

module hd_decode import huff_pkg::*; #(
  parameter int CODE_W = 16  // deepest code the codebook accepts
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              start,      // one cycle pulse from the register block
  output logic              flush,      // clears the fetch buffer when a decode begins
  output logic              need,       // asks the fetch unit to keep a bit ready
  input  logic              bit_valid,
  input  logic              bit_data,
  output logic              bit_take,
  output logic              cb_clear,   // invalidates the whole codebook at start
  output logic              cb_we,      // one write per leaf
  output sym_t              cb_sym,
  output logic [CODE_W-1:0] cb_code,
  output len_t              cb_len,
  output logic              busy,
  output logic              done,
  output logic              error,
  output tot_t              total
);

  dec_state_e        state_q;
  logic [CODE_W-1:0] path_q;    // moves from the root with the newest move in bit 0
  len_t              depth_q;   // number of valid moves in path_q
  sym_t              sym_q;     // symbol being shifted in for the current leaf
  logic [4:0]        cnt_q;     // bit counter for the symbol and total fields
  tot_t              total_q;
  logic              idle_st;   // a start is accepted in this state
  logic              in_bits;   // this state consumes header bits
  logic              take;      // a bit is consumed this cycle
  logic [CODE_W-1:0] pop_path;  // path with its last move removed
  len_t              pop_depth;

  assign idle_st   = (state_q == IDLE) || (state_q == DONE) || (state_q == ERROR);
  assign in_bits   = (state_q == TREE_BIT) || (state_q == LEAF_SYM) || (state_q == TOTAL);
  assign take      = in_bits && bit_valid;
  assign pop_path  = path_q >> 1;
  assign pop_depth = depth_q - len_t'(1);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state_q <= IDLE;
      path_q  <= '0;
      depth_q <= '0;
      sym_q   <= '0;
      cnt_q   <= '0;
      total_q <= '0;
    end else begin
      case (state_q)
        IDLE, DONE, ERROR: begin
          if (start) begin  // fresh walk from the root
            state_q <= TREE_BIT;
            path_q  <= '0;
            depth_q <= '0;
            cnt_q   <= '0;
            total_q <= '0;
          end
        end
        TREE_BIT: begin
          if (take) begin
            if (bit_data) begin
              state_q <= LEAF_SYM;  // a leaf and its symbol follows
              cnt_q   <= '0;
            end else if (depth_q == len_t'(CODE_W)) begin
              state_q <= ERROR;  // one more left move would not fit
            end else begin
              path_q  <= {path_q[CODE_W-2:0], 1'b0};  // internal node so go left
              depth_q <= depth_q + len_t'(1);
            end
          end
        end
        LEAF_SYM: begin
          if (take) begin
            sym_q <= {sym_q[6:0], bit_data};
            cnt_q <= cnt_q + 5'd1;
            if (cnt_q == 5'd7) begin
              state_q <= WRITE;
            end
          end
        end
        WRITE: begin
          if (depth_q == '0) begin
            state_q <= TOTAL;  // root was a leaf so the tree is complete
            cnt_q   <= '0;
          end else if (!path_q[0]) begin
            path_q[0] <= 1'b1;  // left child done and the right sibling comes next
            state_q   <= TREE_BIT;
          end else begin
            state_q <= BACKTRACK;
          end
        end
        BACKTRACK: begin
          // one popped level per cycle and the turn right happens in the same cycle
          path_q  <= pop_path;
          depth_q <= pop_depth;
          if (pop_depth == '0) begin
            state_q <= TOTAL;  // climbed back to the root
            cnt_q   <= '0;
          end else if (!pop_path[0]) begin
            path_q  <= pop_path | CODE_W'(1);
            state_q <= TREE_BIT;
          end
        end
        TOTAL: begin
          if (take) begin
            total_q <= {total_q[30:0], bit_data};
            cnt_q   <= cnt_q + 5'd1;
            if (cnt_q == 5'd31) begin
              state_q <= DONE;
            end
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  assign flush    = idle_st && start;
  assign cb_clear = idle_st && start;  // stale entries vanish before the first write
  assign need     = in_bits;
  assign bit_take = take;
  assign cb_we    = (state_q == WRITE);
  assign cb_sym   = sym_q;
  assign cb_code  = path_q;  // zero when the root itself is a leaf
  assign cb_len   = (depth_q == '0) ? len_t'(1) : depth_q;  // a lone leaf still needs one bit
  assign busy     = !idle_st;
  assign done     = (state_q == DONE);
  assign error    = (state_q == ERROR);
  assign total    = total_q;

endmodule

/* hd_codebook.sv */
`timescale 1ns/1ps

module hd_codebook import huff_pkg::*; #(
  parameter int CODE_W = 16  // width of each stored code
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              clear,    // drops every valid bit in one cycle
  input  logic              we,
  input  sym_t              wr_sym,
  input  logic [CODE_W-1:0] wr_code,
  input  len_t              wr_len,
  input  sym_t              rd_sym,
  output logic              rd_valid,
  output logic [CODE_W-1:0] rd_code,
  output len_t              rd_len
);

  logic [CODE_W-1:0] code_mem [256];  // code per symbol
  len_t              len_mem  [256];  // length per symbol
  logic [255:0]      valid_q;         // entry written since the last clear

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      valid_q <= '0;
    end else if (clear) begin
      valid_q <= '0;  // a new decode starts with an empty table
    end else if (we) begin
      valid_q[wr_sym] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (we) begin
      code_mem[wr_sym] <= wr_code;
      len_mem[wr_sym]  <= wr_len;
    end
  end

  assign rd_valid = valid_q[rd_sym];  // asynchronous read for the APB mux
  assign rd_code  = code_mem[rd_sym];
  assign rd_len   = len_mem[rd_sym];

endmodule

/* hd_apb_regs.sv */
`timescale 1ns/1ps

module hd_apb_regs import huff_pkg::*; #(
  parameter int CODE_W = 16  // must stay at or below 24 to fit REG_CODE
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              psel,
  input  logic              penable,
  input  logic              pwrite,
  input  apb_addr_t         paddr,
  input  apb_data_t         pwdata,
  output apb_data_t         prdata,
  output logic              pready,
  output logic              pslverr,
  output logic              start,     // one cycle pulse into the decoder
  input  logic              busy,
  input  logic              done,
  input  logic              error,
  input  tot_t              total,
  output sym_t              rd_sym,    // codebook entry shown in REG_CODE
  input  logic              rd_valid,
  input  logic [CODE_W-1:0] rd_code,
  input  len_t              rd_len
);

  logic  access;   // APB access phase
  logic  mapped;   // paddr hits one of the five registers
  logic  start_q;
  sym_t  index_q;  // host selected codebook index

  assign access = psel && penable;
  assign mapped = (paddr == REG_CTRL) || (paddr == REG_STATUS) || (paddr == REG_TOTAL) ||
                  (paddr == REG_INDEX) || (paddr == REG_CODE);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      start_q <= 1'b0;
      index_q <= '0;
    end else begin
      // a start during a running decode is dropped here
      start_q <= access && pwrite && (paddr == REG_CTRL) && pwdata[0] && !busy;
      if (access && pwrite && (paddr == REG_INDEX)) begin
        index_q <= pwdata[7:0];
      end
    end
  end

  always_comb begin
    prdata = '0;  // CTRL and unmapped addresses read as zero
    case (paddr)
      REG_STATUS: begin
        prdata[STAT_BUSY]  = busy;
        prdata[STAT_DONE]  = done;
        prdata[STAT_ERROR] = error;
      end
      REG_TOTAL: prdata = total;
      REG_INDEX: prdata = apb_data_t'(index_q);
      REG_CODE: begin
        prdata[CODE_VALID_BIT]                = rd_valid;
        prdata[CODE_VALID_BIT-1:CODE_LEN_LSB] = rd_len[6:0];
        prdata[CODE_FIELD_W-1:0]              = CODE_FIELD_W'(rd_code);  // right aligned
      end
      default: prdata = '0;
    endcase
  end

  assign pready  = 1'b1;  // every access completes without wait states
  assign pslverr = access && !mapped;
  assign start   = start_q;
  assign rd_sym  = index_q;

endmodule

/* hd_top.sv */
`timescale 1ns/1ps

module hd_top import huff_pkg::*; #(
  parameter int CODE_W = 16  // maximum code length passed to every block
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      psel,
  input  logic      penable,
  input  logic      pwrite,
  input  apb_addr_t paddr,
  input  apb_data_t pwdata,
  output apb_data_t prdata,
  output logic      pready,
  output logic      pslverr,
  output logic      byte_req,    // to the external header byte source
  input  logic      byte_valid,
  input  byte_t     byte_data
);

  logic              flush, need, bit_valid, bit_data, bit_take;  // fetch to decode
  logic              cb_clear, cb_we;                              // decode to codebook
  sym_t              cb_sym;
  logic [CODE_W-1:0] cb_code;
  len_t              cb_len;
  logic              start, busy, done, error;                     // decode to registers
  tot_t              total;
  sym_t              rd_sym;                                       // registers to codebook
  logic              rd_valid;
  logic [CODE_W-1:0] rd_code;
  len_t              rd_len;

  hd_bit_fetch hd_bit_fetch_i (
    .clk, .rst, .flush, .need, .byte_req, .byte_valid, .byte_data,
    .bit_valid, .bit_data, .bit_take
  );

  hd_decode #(.CODE_W(CODE_W)) hd_decode_i (
    .clk, .rst, .start, .flush, .need, .bit_valid, .bit_data, .bit_take,
    .cb_clear, .cb_we, .cb_sym, .cb_code, .cb_len, .busy, .done, .error, .total
  );

  hd_codebook #(.CODE_W(CODE_W)) hd_codebook_i (
    .clk, .rst, .clear(cb_clear), .we(cb_we), .wr_sym(cb_sym), .wr_code(cb_code),
    .wr_len(cb_len), .rd_sym, .rd_valid, .rd_code, .rd_len
  );

  hd_apb_regs #(.CODE_W(CODE_W)) hd_apb_regs_i (
    .clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
    .start, .busy, .done, .error, .total, .rd_sym, .rd_valid, .rd_code, .rd_len
  );

endmodule

/* hd_props.sv */
`timescale 1ns/1ps

module hd_props (
  input logic clk,
  input logic rst,
  input logic byte_req,
  input logic byte_valid,
  input logic psel,
  input logic penable,
  input logic pslverr,
  input logic done,
  input logic error
);

  logic out_q;  // a byte request is waiting for its answer

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      out_q <= 1'b0;
    end else if (byte_req) begin
      out_q <= 1'b1;
    end else if (byte_valid) begin
      out_q <= 1'b0;  // the answer closes the request
    end
  end

  single_req: assert property (@(posedge clk) disable iff (rst) byte_req |-> !out_q)
    else $error("byte request raised while another request is outstanding");

  done_xor_error: assert property (@(posedge clk) disable iff (rst) !(done && error))
    else $error("done and error are high together");

  slverr_in_access: assert property (@(posedge clk) disable iff (rst)
                                     pslverr |-> (psel && penable))
    else $error("pslverr raised outside an APB access phase");

endmodule

bind hd_top hd_props hd_props_i (
  .clk(clk), .rst(rst), .byte_req(byte_req), .byte_valid(byte_valid), .psel(psel),
  .penable(penable), .pslverr(pslverr), .done(done), .error(error)
);

/* tb_hd_top.sv */
`timescale 1ns/1ps

module tb_hd_top import huff_pkg::*; ();

  localparam int CODE_W      = 16;
  localparam int PERIOD      = 100;
  localparam int NUM_TESTS   = 10;
  localparam int TEST_CYCLES = 4000;  // longest header plus 512 register transfers of 3 cycles

  logic              clk, rst, psel, penable, pwrite, pready, pslverr;
  logic              byte_req, byte_valid;
  apb_addr_t         paddr;
  apb_data_t         pwdata, prdata;
  byte_t             byte_data;

  bit                hdr_bits[$];      // header as a bit stream with the tree first
  byte_t             src_q[$];         // bytes the source model still has to deliver
  logic              exp_valid[256];   // expected codebook contents
  logic [CODE_W-1:0] exp_code[256];
  len_t              exp_len[256];
  logic              exp_err;          // the tree is too deep for the codebook
  tot_t              exp_total;
  logic [31:0]       gen_rng, dly_rng;  // separate streams for tree shapes and source delays
  int                mismatches, failures;
  int unsigned       src_wait;         // cycles left before the pending byte is answered
  logic              src_pend;

  hd_top #(.CODE_W(CODE_W)) hd_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic logic [31:0] next_gen();
    gen_rng = xorshift(gen_rng);
    return gen_rng;
  endfunction

  function automatic void push_bits(input logic [31:0] v, input int n);
    for (int i = n - 1; i >= 0; i--) hdr_bits.push_back(v[i]);  // MSB first as in the header
  endfunction

  function automatic void build_random(input int max_leaves, input int max_depth);
    int   pend[$];  // depths of nodes still to be emitted in pre-order
    bit   used[256];
    int   d;
    int   leaves;
    sym_t s;
    foreach (used[i]) used[i] = 1'b0;
    leaves = 0;
    pend.push_back(0);
    while (pend.size() > 0) begin
      d = pend.pop_back();
      if (d < max_depth && leaves + pend.size() + 2 <= max_leaves && next_gen() % 4 != 0) begin
        hdr_bits.push_back(1'b0);  // internal node whose two children sit one level down
        pend.push_back(d + 1);
        pend.push_back(d + 1);
      end else begin
        do s = sym_t'(next_gen()); while (used[s]);  // every leaf gets its own symbol
        used[s] = 1'b1;
        leaves++;
        hdr_bits.push_back(1'b1);
        push_bits(32'(s), 8);
      end
    end
  endfunction

  function automatic void build_comb(input int levels);
    for (int i = 0; i < levels; i++) hdr_bits.push_back(1'b0);  // left spine of internal nodes
    for (int i = 0; i <= levels; i++) begin
      hdr_bits.push_back(1'b1);
      push_bits(32'(i * 37 + 5), 8);  // odd stride keeps the symbols distinct
    end
  endfunction

  // walks the pre-order stream with a node stack, left is 0 and right is 1 from the root down
  function automatic void ref_decode();
    logic [CODE_W-1:0] st_code[$];
    int                st_len[$];
    logic [CODE_W-1:0] code;
    int                len;
    int                p;
    sym_t              s;
    foreach (exp_valid[i]) exp_valid[i] = 1'b0;
    exp_err   = 1'b0;
    exp_total = '0;
    p         = 0;
    st_code.push_back('0);
    st_len.push_back(0);
    while (st_len.size() > 0 && !exp_err) begin
      code = st_code.pop_back();
      len  = st_len.pop_back();
      if (hdr_bits[p] == 1'b0) begin
        p++;
        if (len == CODE_W) begin
          exp_err = 1'b1;  // its children would need more than CODE_W bits
        end else begin
          st_code.push_back({code[CODE_W-2:0], 1'b1});  // right child waits below the left
          st_len.push_back(len + 1);
          st_code.push_back({code[CODE_W-2:0], 1'b0});
          st_len.push_back(len + 1);
        end
      end else begin
        s = '0;
        for (int k = 1; k <= 8; k++) s = {s[6:0], hdr_bits[p + k]};
        p += 9;
        exp_valid[s] = 1'b1;
        exp_code[s]  = code;
        exp_len[s]   = (len == 0) ? len_t'(1) : len_t'(len);  // a lone root leaf still costs a bit
      end
    end
    if (!exp_err) begin
      for (int k = 0; k < 32; k++) exp_total = {exp_total[30:0], hdr_bits[p + k]};
    end
  endfunction

  function automatic void pack_header();
    byte_t b;
    src_q.delete();
    while (hdr_bits.size() % 8 != 0) hdr_bits.push_back(1'b0);  // zero pad the last byte
    for (int i = 0; i < hdr_bits.size(); i += 8) begin
      for (int j = 0; j < 8; j++) b[7 - j] = hdr_bits[i + j];
      src_q.push_back(b);
    end
  endfunction

  // header byte source that answers each request after 1 to 6 cycles
  initial begin
    byte_valid = 1'b0;
    byte_data  = '0;
    src_pend   = 1'b0;
    src_wait   = 0;
    forever begin
      @(posedge clk);
      byte_valid <= 1'b0;
      if (byte_req) begin
        dly_rng  = xorshift(dly_rng);
        src_pend = 1'b1;
        src_wait = dly_rng % 6;  // zero extra wait answers in the very next cycle
      end
      if (src_pend) begin
        if (src_wait == 0) begin
          src_pend = 1'b0;
          if (src_q.size() == 0) begin
            failures++;
            $display("the byte source was asked for more bytes than the header holds");
          end else begin
            byte_valid <= 1'b1;
            byte_data  <= src_q.pop_front();
          end
        end else begin
          src_wait--;
        end
      end
    end
  end

  task automatic check_code(input string name, input logic [CODE_W-1:0] got, exp);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_len(input string name, input len_t got, exp);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_total(input string name, input tot_t got, exp);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, exp);
    if (got !== exp) begin
      mismatches++;
      $display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic apb_write(input apb_addr_t a, input apb_data_t d);
    @(posedge clk);
    psel    <= 1'b1;  // setup phase
    pwrite  <= 1'b1;
    paddr   <= a;
    pwdata  <= d;
    @(posedge clk);
    penable <= 1'b1;
    @(posedge clk);  // no wait states so the access ends on this edge
    check_flag("pready", pready, 1'b1);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_read(input apb_addr_t a, output apb_data_t d, output logic err);
    @(posedge clk);
    psel    <= 1'b1;
    pwrite  <= 1'b0;
    paddr   <= a;
    @(posedge clk);
    penable <= 1'b1;
    @(posedge clk);
    check_flag("pready", pready, 1'b1);
    d       = prdata;  // read data is valid in the access phase
    err     = pslverr;
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic run_test(input int t);
    apb_data_t w;
    logic      err;
    int        max_leaves;
    int        max_depth;
    hdr_bits.delete();
    max_leaves = 2 + int'(next_gen() % 63);
    max_depth  = 3 + int'(next_gen() % 10);  // stays below CODE_W so random trees are legal
    case (t)
      6: build_comb(0);           // the root itself is a leaf
      7: build_comb(CODE_W);      // deepest code the codebook can hold
      8: build_comb(CODE_W + 1);  // one level too deep
      default: build_random(max_leaves, max_depth);
    endcase
    push_bits(next_gen(), 32);  // symbol total follows the tree
    ref_decode();
    pack_header();
    apb_write(REG_CTRL, 32'd1);
    if (t == 5) begin
      apb_write(REG_CTRL, 32'd1);  // second start lands while the decode runs
      apb_read(REG_STATUS, w, err);
      check_flag("status busy", w[STAT_BUSY], 1'b1);
    end
    do apb_read(REG_STATUS, w, err); while (!w[STAT_DONE] && !w[STAT_ERROR]);
    check_flag("status done", w[STAT_DONE], !exp_err);
    check_flag("status error", w[STAT_ERROR], exp_err);
    if (!exp_err) begin
      apb_read(REG_TOTAL, w, err);
      check_flag("pslverr total", err, 1'b0);
      check_total("total", w, exp_total);
      for (int i = 0; i < 256; i++) begin
        apb_write(REG_INDEX, apb_data_t'(i));
        apb_read(REG_CODE, w, err);
        check_flag($sformatf("valid[%0d]", i), w[CODE_VALID_BIT], exp_valid[i]);
        if (exp_valid[i]) begin
          check_code($sformatf("code[%0d]", i), w[CODE_W-1:0], exp_code[i]);
          check_len($sformatf("len[%0d]", i), {1'b0, w[30:24]}, exp_len[i]);
        end
      end
    end
  endtask

  initial begin
    apb_data_t w;
    logic      err;
    rst        = 1'b1;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    mismatches = 0;
    failures   = 0;
    gen_rng    = 32'd77998;
    dly_rng    = xorshift(32'd77998);
    repeat (10) @(posedge clk);
    rst <= 1'b0;
    apb_read(8'h14, w, err);  // first address past the register map
    check_flag("pslverr unmapped", err, 1'b1);
    apb_read(REG_STATUS, w, err);
    check_flag("pslverr status", err, 1'b0);
    for (int t = 0; t < NUM_TESTS; t++) run_test(t);
    $display("tests %0d mismatches %0d other failures %0d", NUM_TESTS, mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #(NUM_TESTS * TEST_CYCLES * PERIOD);
    $display("timeout after %0d ns with the tests still running",
             NUM_TESTS * TEST_CYCLES * PERIOD);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

/* build.f */
huff_pkg.sv
hd_bit_fetch.sv
hd_decode.sv
hd_codebook.sv
hd_apb_regs.sv
hd_top.sv
hd_props.sv
tb_hd_top.sv

/* Makefile */
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f build.f --top-module tb_hd_top

sim:
	verilator --binary --timing --assert -f build.f --top-module tb_hd_top -o sim_tb
	./obj_dir/sim_tb | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || { echo "simulation ended without a verdict"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
